// ==== hdl/ym_op_pkg.sv ====
package ym_op_pkg;

	typedef logic [9:0] phase_t;
	typedef logic [7:0] qidx_t;
	typedef logic [9:0] eg_att_t;
	typedef logic [11:0] logsin_t;
	// Bit 12 set means the log attenuation ran past full scale
	typedef logic [12:0] att_sum_t;
	typedef logic signed [13:0] op_out_t;

	localparam int LOGSIN_ROW_W = 46;
	localparam int EXP_ROW_W = 48;

	// Phase and logsin take one cycle each, exp takes three
	localparam int OP_LATENCY = 5;

	// Log-sine rows, addressed by quarter-wave index bits 5:1
	localparam logic [LOGSIN_ROW_W-1:0] LOGSIN_ROM [0:31] = '{
		46'b1110011111010001110111100110011001110101111010,
		46'b1011010110110011110111011000011100110000011010,
		46'b1010010111110101100010001011110001010100001010,
		46'b1010000101011111111100100101011100010010010011,
		46'b1010000100011011011001011110010001110010101001,
		46'b0111010101011011001001100100010000110100110010,
		46'b0111010100011001001100011010011100010000101001,
		46'b0111000101010101010100101000110000010010010001,
		46'b0111000100000100101111110111011101010010111011,
		46'b0111000100000000101111000101010101010101111001,
		46'b0100110111001100110110110111110001010111110000,
		46'b0100110111001000110010111100101010001100010111,
		46'b0100110110001100010011011010111110110100011000,
		46'b0100110110001000001011101000001010111011111011,
		46'b0100100111001100001011011000001001011000011011,
		46'b0100100111000100010000101110001101001011111110,
		46'b0100100111000000010000011101000110101110010111,
		46'b0100100010010100101001101111110110100101100100,
		46'b0100100010010100100001001111000001111110100010,
		46'b0100100010010000100001011100100000111001111011,
		46'b0001110001011100111000111110100011001001110111,
		46'b0001110001011100110000011011100100001010100111,
		46'b0001110001011000101000111001100101011001101010,
		46'b0001110001011000000001110010101110001101110111,
		46'b0001110000011100001001010011101000101111001111,
		46'b0001110000010100011001100001001011001110100101,
		46'b0001110000010100010001100000001000101110100111,
		46'b0001110000010000011000000011101010001110010110,
		46'b0001110000010000000000110011001001001100100111,
		46'b0001100001010100001000110000101011001100000110,
		46'b0001100001010100001000000001001001001100010100,
		46'b0001100001000100100001000010101010101000100101
	};

endpackage

// ==== hdl/ym_op_phase.sv ====
module ym_op_phase
	import ym_op_pkg::*;
	(
	input  logic    mclk_i,
	input  logic    rst_i,
	input  logic    valid_i,
	input  phase_t  phase_i,
	input  phase_t  mod_i,
	input  eg_att_t eg_att_i,
	output logic    valid_o,
	output qidx_t   qidx_o,
	output logic    sign_o,
	output eg_att_t eg_att_o
	);

	phase_t phase_sum;
	phase_t phase_sum_q;
	eg_att_t eg_att_q;
	logic valid_q;

	// Wraps modulo 1024
	assign phase_sum = phase_i + mod_i;

	always_ff @(posedge mclk_i)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= valid_i;
	end

	always_ff @(posedge mclk_i)
	begin
		phase_sum_q <= phase_sum;
		eg_att_q <= eg_att_i;
	end

	// Second quarter of each half wave runs the table backwards
	assign qidx_o = phase_sum_q[7:0] ^ {8{phase_sum_q[8]}};
	assign sign_o = phase_sum_q[9];
	assign eg_att_o = eg_att_q;
	assign valid_o = valid_q;

endmodule

// ==== hdl/ym_op_logsin.sv ====
module ym_op_logsin
	import ym_op_pkg::*;
	(
	input  logic    mclk_i,
	input  logic    rst_i,
	input  logic    valid_i,
	input  qidx_t   qidx_i,
	input  logic    sign_i,
	input  eg_att_t eg_att_i,
	output logic    valid_o,
	output logsin_t logsin_o,
	output logic    sign_o,
	output eg_att_t eg_att_o
	);

	logic [LOGSIN_ROW_W-1:0] row;
	logic [18:0] row_sel;
	logic [18:0] row_sel_q;
	logic idx_lsb_q;
	logic sign_q;
	eg_att_t eg_att_q;
	logic valid_q;
	logic [10:0] sin_base;
	logic [7:0] sin_delta;

	assign row = LOGSIN_ROM[qidx_i[5:1]];

	// Upper index bits pick which interleaved column group feeds each field bit
	always_comb
	begin
		case (qidx_i[7:6])
			2'd0: row_sel = {row[45], row[44], row[42], row[40], row[39], row[36], row[35],
				row[32], row[31], row[27], row[26], row[22], row[21], row[17], row[15],
				row[11], row[8], row[4], row[0]};
			2'd1: row_sel = {2'b0, row[43], row[41], 1'b0, row[37], 1'b0, row[33], 1'b0,
				row[28], 1'b0, row[23], 1'b0, row[18], row[16], row[12], row[9], row[5],
				row[1]};
			2'd2: row_sel = {5'b0, row[38], 1'b0, row[34], 1'b0, row[29], 1'b0, row[24],
				1'b0, row[19], 1'b0, row[13], row[10], row[6], row[2]};
			default: row_sel = {9'b0, row[30], 1'b0, row[25], 1'b0, row[20], 1'b0, row[14],
				1'b0, row[7], row[3]};
		endcase
	end

	always_ff @(posedge mclk_i)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= valid_i;
	end

	always_ff @(posedge mclk_i)
	begin
		row_sel_q <= row_sel;
		idx_lsb_q <= qidx_i[0];
		sign_q <= sign_i;
		eg_att_q <= eg_att_i;
	end

	// Base and delta bits are interleaved in the selected column
	assign sin_base = {row_sel_q[18:15], row_sel_q[13], row_sel_q[11], row_sel_q[9],
		row_sel_q[7], row_sel_q[5], row_sel_q[3], row_sel_q[1]};

	// Odd entries sit on the table row, even entries interpolate
	assign sin_delta = idx_lsb_q ? 8'h00 : {row_sel_q[14], row_sel_q[12], row_sel_q[10],
		row_sel_q[8], row_sel_q[6], row_sel_q[4], row_sel_q[2], row_sel_q[0]};

	assign logsin_o = logsin_t'(sin_base) + logsin_t'({sin_delta[7], sin_delta});
	assign sign_o = sign_q;
	assign eg_att_o = eg_att_q;
	assign valid_o = valid_q;

endmodule

// ==== hdl/ym_op_exp.sv ====
module ym_op_exp
	import ym_op_pkg::*;
	(
	input  logic    mclk_i,
	input  logic    rst_i,
	input  logic    valid_i,
	input  logsin_t logsin_i,
	input  logic    sign_i,
	input  eg_att_t eg_att_i,
	output logic    valid_o,
	output op_out_t out_o
	);

	// Everything after the phase and logsin registers
	localparam int EXP_DEPTH = OP_LATENCY - 2;

	logic [EXP_DEPTH-1:0] valid_q;
	att_sum_t att_sum;
	logic [11:0] att_clamp;
	logic [11:0] att_clamp_q;
	logic sign_a_q;
	logic [7:0] exp_idx;
	logic [EXP_ROW_W-1:0] exp_row;
	logic [12:0] exp_sel;
	logic [12:0] exp_sel_q;
	logic exp_lsb_q;
	logic [3:0] shift_q;
	logic sign_b_q;
	logic [9:0] mant_base;
	logic [2:0] mant_delta;
	logic [9:0] mant;
	logic [12:0] shift1;
	logic [12:0] shift2;
	logic [13:0] magnitude;
	logic [13:0] sample;
	op_out_t out_q;

	assign att_sum = att_sum_t'(logsin_i) + att_sum_t'({eg_att_i, 2'b00});
	// Overflow pins at full attenuation, inversion turns attenuation into level
	assign att_clamp = ~(att_sum[12] ? 12'hfff : att_sum[11:0]);

	assign exp_idx = att_clamp_q[7:0];

	always_comb
	begin
		case (exp_idx[5:1])
			5'h00: exp_row = 48'b100101110001011001000110011000000011101010110000;
			5'h01: exp_row = 48'b100101110101001000100001011101001001000100000000;
			5'h02: exp_row = 48'b100101110101001000100111111001010011001110111011;
			5'h03: exp_row = 48'b100101110111000001011000011001010011101010110001;
			5'h04: exp_row = 48'b100101110111010000011011011100011001000110010000;
			5'h05: exp_row = 48'b100101110111010100101100111100001001001010011010;
			5'h06: exp_row = 48'b100101110111010111100011011000000011101110111000;
			5'h07: exp_row = 48'b100101110111011111010100111001000011000010101010;
			5'h08: exp_row = 48'b101100110011001110010011111001001011100010110001;
			5'h09: exp_row = 48'b101100110011001111111001011000010011001111110011;
			5'h0a: exp_row = 48'b101110100010001011101110111000010011101010110101;
			5'h0b: exp_row = 48'b111010000000010010001001111101011001000110010101;
			5'h0c: exp_row = 48'b111010000000110000010110011001011011100011110101;
			5'h0d: exp_row = 48'b111010000000110001110101111000000011011110110011;
			5'h0e: exp_row = 48'b111010000100100100101010011000000011111010110001;
			5'h0f: exp_row = 48'b111010000100101100001101011001001011010110110111;
			5'h10: exp_row = 48'b111010000100101101011010111101001001110011010101;
			5'h11: exp_row = 48'b111010000100111110110000011100110001001110010011;
			5'h12: exp_row = 48'b111010000100111110110111111100110101101001010001;
			5'h13: exp_row = 48'b111010000111110011000000111001111011001110111101;
			5'h14: exp_row = 48'b111010000111110011001111011101111001110010011011;
			5'h15: exp_row = 48'b111011000011100010111100111100110001110110010101;
			5'h16: exp_row = 48'b111011001011000001110011011101110001010111010100;
			5'h17: exp_row = 48'b111011001011001101000110111101000001101011011010;
			5'h18: exp_row = 48'b111011001011011100100101111100001001001111011110;
			5'h19: exp_row = 48'b111011001011011101111010011111001000011011000000;
			5'h1a: exp_row = 48'b111011101001010101011101111101000001111111011101;
			5'h1b: exp_row = 48'b111011111100000010000110011100100101000001011011;
			5'h1c: exp_row = 48'b111011111100000011100001111101100101000001010110;
			5'h1d: exp_row = 48'b111011111100000011110110111101101001110111011010;
			5'h1e: exp_row = 48'b111011111100011010011111011000001011100010110011;
			default: exp_row = 48'b111011111100011111101000111101000001000110011101;
		endcase
	end

	always_comb
	begin
		case (exp_idx[7:6])
			2'd0: exp_sel = {2'b0, exp_row[39], exp_row[35], exp_row[31], exp_row[27],
				exp_row[23], exp_row[19], exp_row[15], exp_row[12], exp_row[8], exp_row[4],
				exp_row[0]};
			2'd1: exp_sel = {1'b0, exp_row[43], exp_row[40], exp_row[36], exp_row[32],
				exp_row[28], exp_row[24], exp_row[20], exp_row[16], exp_row[13], exp_row[9],
				exp_row[5], exp_row[1]};
			2'd2: exp_sel = {exp_row[46], exp_row[44], exp_row[41], exp_row[37], exp_row[33],
				exp_row[29], exp_row[25], exp_row[21], exp_row[17], 1'b0, exp_row[10],
				exp_row[6], exp_row[2]};
			default: exp_sel = {exp_row[47], exp_row[45], exp_row[42], exp_row[38],
				exp_row[34], exp_row[30], exp_row[26], exp_row[22], exp_row[18], exp_row[14],
				exp_row[11], exp_row[7], exp_row[3]};
		endcase
	end

	// Mantissa with interpolation, implied leading one added by the shifter
	assign mant_base = {exp_sel_q[12:6], exp_sel_q[4], exp_sel_q[2], exp_sel_q[0]};
	assign mant_delta = exp_lsb_q ? {exp_sel_q[5], exp_sel_q[3], exp_sel_q[1]} : 3'd0;
	assign mant = mant_base + 10'(mant_delta);

	always_comb
	begin
		case (shift_q[1:0])
			2'd3: shift1 = {1'b1, mant, 2'b00};
			2'd2: shift1 = {1'b0, 1'b1, mant, 1'b0};
			2'd1: shift1 = {2'b0, 1'b1, mant};
			default: shift1 = {3'b0, 1'b1, mant[9:1]};
		endcase
		case (shift_q[3:2])
			2'd3: shift2 = shift1;
			2'd2: shift2 = {4'b0, shift1[12:4]};
			2'd1: shift2 = {8'b0, shift1[12:8]};
			default: shift2 = '0;
		endcase
	end

	assign magnitude = {1'b0, shift2};
	assign sample = (magnitude ^ {14{sign_b_q}}) + 14'(sign_b_q);

	always_ff @(posedge mclk_i)
	begin
		if (rst_i)
		begin
			valid_q <= '0;
			out_q <= '0;
		end
		else
		begin
			valid_q <= {valid_q[EXP_DEPTH-2:0], valid_i};
			// Output holds its last sample between valid strobes
			if (valid_q[EXP_DEPTH-2])
				out_q <= sample;
		end
	end

	always_ff @(posedge mclk_i)
	begin
		att_clamp_q <= att_clamp;
		sign_a_q <= sign_i;
		exp_sel_q <= exp_sel;
		exp_lsb_q <= exp_idx[0];
		shift_q <= att_clamp_q[11:8];
		sign_b_q <= sign_a_q;
	end

	assign valid_o = valid_q[EXP_DEPTH-1];
	assign out_o = out_q;

endmodule

// ==== hdl/ym_op_core.sv ====
module ym_op_core
	import ym_op_pkg::*;
	(
	input  logic    mclk_i,
	input  logic    rst_i,
	input  logic    valid_i,
	input  phase_t  phase_i,
	input  phase_t  mod_i,
	input  eg_att_t eg_att_i,
	output logic    valid_o,
	output op_out_t out_o
	);

	logic ph_valid;
	qidx_t ph_qidx;
	logic ph_sign;
	eg_att_t ph_eg_att;

	logic ls_valid;
	logsin_t ls_logsin;
	logic ls_sign;
	eg_att_t ls_eg_att;

	ym_op_phase u_phase
		(
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.phase_i(phase_i),
		.mod_i(mod_i),
		.eg_att_i(eg_att_i),
		.valid_o(ph_valid),
		.qidx_o(ph_qidx),
		.sign_o(ph_sign),
		.eg_att_o(ph_eg_att)
		);

	ym_op_logsin u_logsin
		(
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.valid_i(ph_valid),
		.qidx_i(ph_qidx),
		.sign_i(ph_sign),
		.eg_att_i(ph_eg_att),
		.valid_o(ls_valid),
		.logsin_o(ls_logsin),
		.sign_o(ls_sign),
		.eg_att_o(ls_eg_att)
		);

	ym_op_exp u_exp
		(
		.mclk_i(mclk_i),
		.rst_i(rst_i),
		.valid_i(ls_valid),
		.logsin_i(ls_logsin),
		.sign_i(ls_sign),
		.eg_att_i(ls_eg_att),
		.valid_o(valid_o),
		.out_o(out_o)
		);

endmodule

// ==== test/ym_op_checker.sv ====
module ym_op_checker
	import ym_op_pkg::*;
	(
	input  logic    mclk_i,
	input  logic    rst_i,
	input  logic    in_valid_i,
	input  int      in_test_i,
	input  op_out_t in_expect_i,
	input  logic    out_valid_i,
	input  op_out_t out_i,
	output int      pending_o,
	output int      pass_count_o,
	output int      fail_count_o
	);

	timeunit 1ns;
	timeprecision 1ps;

	int cycle = 0;
	int pushed = 0;
	int popped = 0;
	int checked = 0;
	int pass_count = 0;
	int fail_count = 0;
	int want_q[$];
	int test_q[$];
	int cycle_q[$];
	int last_test = 0;
	logic have_first = 1'b0;
	op_out_t first_out = '0;

	assign pending_o = pushed - popped;
	assign pass_count_o = pass_count;
	assign fail_count_o = fail_count;

	// Inputs are taken on the rising edge, as the DUT takes them
	always @(posedge mclk_i)
	begin
		if (!rst_i && in_valid_i)
		begin
			want_q.push_back(int'(in_expect_i));
			test_q.push_back(in_test_i);
			cycle_q.push_back(cycle);
			pushed = pushed + 1;
		end
	end

	// Outputs have settled by the falling edge
	always @(negedge mclk_i)
	begin
		cycle = cycle + 1;
		if (out_valid_i)
			check_output();
	end

	// Pairs of sign, mirror and modulation vectors, and full attenuation
	task automatic check_rule(input int test, output logic rule_ok);
		int pair_want;
		rule_ok = 1'b1;
		if (test != last_test)
			have_first = 1'b0;
		last_test = test;
		if (test == 6)
		begin
			assert (int'(out_i) == 0)
			else
			begin
				$display("MISMATCH at %0t ns: out_o got %0d expected 0", $time, out_i);
				rule_ok = 1'b0;
			end
		end
		else if (test >= 3 && test <= 5)
		begin
			if (!have_first)
			begin
				first_out = out_i;
				have_first = 1'b1;
			end
			else
			begin
				have_first = 1'b0;
				pair_want = (test == 3) ? -int'(first_out) : int'(first_out);
				assert (int'(out_i) == pair_want)
				else
				begin
					$display("MISMATCH at %0t ns: out_o got %0d expected %0d from its pair",
						$time, out_i, pair_want);
					rule_ok = 1'b0;
				end
			end
		end
	endtask

	task automatic check_output();
		int want;
		int test;
		int start;
		logic ok;
		logic rule_ok;
		assert (want_q.size() > 0)
		else
		begin
			$display("ERROR at %0t ns: valid_o was high with no input waiting for it", $time);
			fail_count = fail_count + 1;
		end
		if (want_q.size() > 0)
		begin
			want = want_q.pop_front();
			test = test_q.pop_front();
			start = cycle_q.pop_front();
			popped = popped + 1;
			checked = checked + 1;
			ok = 1'b1;
			assert (cycle - start == OP_LATENCY)
			else
			begin
				$display("ERROR at %0t ns: output came %0d cycles after its input, not %0d",
					$time, cycle - start, OP_LATENCY);
				ok = 1'b0;
			end
			assert (int'(out_i) == want)
			else
			begin
				$display("MISMATCH at %0t ns: out_o got %0d expected %0d", $time, out_i, want);
				ok = 1'b0;
			end
			check_rule(test, rule_ok);
			ok = ok & rule_ok;
			$display("test %0d, behavior %0d: out_o = %0d, %s", checked, test, out_i,
				ok ? "ok" : "failed");
			if (ok)
				pass_count = pass_count + 1;
			else
				fail_count = fail_count + 1;
		end
	endtask

endmodule

// ==== test/tb_ym_op.sv ====
module tb_ym_op
	import ym_op_pkg::*;
	();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 2;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES = 10;
	localparam int DRAIN_LIMIT = 50;
	localparam int MAX_LINES = 1000;
	localparam string VECTOR_FILE = "test/ym_op_vectors.txt";

	logic mclk;
	logic rst;
	logic valid;
	phase_t phase;
	phase_t modulation;
	eg_att_t eg_att;
	logic out_valid;
	op_out_t out_data;
	int test_id;
	op_out_t expect_val;
	int pending;
	int pass_count;
	int fail_count;
	int seed = 32'h954e;
	int own_pass = 0;
	int own_fail = 0;

	ym_op_core u_ym_op_core
		(
		.mclk_i(mclk),
		.rst_i(rst),
		.valid_i(valid),
		.phase_i(phase),
		.mod_i(modulation),
		.eg_att_i(eg_att),
		.valid_o(out_valid),
		.out_o(out_data)
		);

	ym_op_checker u_ym_op_checker
		(
		.mclk_i(mclk),
		.rst_i(rst),
		.in_valid_i(valid),
		.in_test_i(test_id),
		.in_expect_i(expect_val),
		.out_valid_i(out_valid),
		.out_i(out_data),
		.pending_o(pending),
		.pass_count_o(pass_count),
		.fail_count_o(fail_count)
		);

	initial
	begin
		mclk = 1'b0;
		forever
			#HALF_PERIOD mclk = ~mclk;
	end

	task automatic drive_vector(input int test, input int ph, input int md, input int att,
		input int want);
		@(negedge mclk);
		valid = 1'b1;
		phase = phase_t'(ph);
		modulation = phase_t'(md);
		eg_att = eg_att_t'(att);
		test_id = test;
		expect_val = op_out_t'(want);
	endtask

	// Idle cycles carry junk data that the DUT must ignore
	task automatic idle_gap(input int cycles);
		repeat (cycles)
		begin
			@(negedge mclk);
			valid = 1'b0;
			phase = phase_t'($random(seed));
			modulation = phase_t'($random(seed));
			eg_att = eg_att_t'($random(seed));
		end
	endtask

	task automatic check_idle();
		logic ok;
		ok = 1'b1;
		repeat (IDLE_CYCLES)
		begin
			@(negedge mclk);
			assert (out_valid == 1'b0)
			else
			begin
				$display("MISMATCH at %0t ns: valid_o got %0b expected 0", $time, out_valid);
				ok = 1'b0;
			end
			assert (out_data == '0)
			else
			begin
				$display("MISMATCH at %0t ns: out_o got %0d expected 0", $time, out_data);
				ok = 1'b0;
			end
		end
		$display("test idle after reset: %s", ok ? "ok" : "failed");
		if (ok)
			own_pass = own_pass + 1;
		else
			own_fail = own_fail + 1;
	endtask

	task automatic run_vectors();
		int fd;
		int r;
		int lines;
		int gap;
		int test;
		int ph;
		int md;
		int att;
		int want;
		string line;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
		begin
			$display("ERROR: cannot open the vector file %s", VECTOR_FILE);
			own_fail = own_fail + 1;
			return;
		end
		lines = 0;
		while (!$feof(fd) && lines < MAX_LINES)
		begin
			lines = lines + 1;
			r = $fgets(line, fd);
			if (r == 0 || line.len() < 2 || line[0] == "#")
				continue;
			r = $sscanf(line, "%d %h %h %h %d", test, ph, md, att, want);
			if (r != 5)
			begin
				$display("ERROR: vector line %0d cannot be read", lines);
				own_fail = own_fail + 1;
				continue;
			end
			drive_vector(test, ph, md, att, want);
			gap = $random(seed) & 7;
			if (gap < 4)
				idle_gap(gap);
		end
		$fclose(fd);
		idle_gap(1);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (pending != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge mclk);
			waited = waited + 1;
		end
		if (pending != 0)
		begin
			$display("ERROR: %0d outputs still missing after %0d cycles", pending, DRAIN_LIMIT);
			own_fail = own_fail + 1;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		valid = 1'b0;
		phase = '0;
		modulation = '0;
		eg_att = '0;
		test_id = 0;
		expect_val = '0;
		repeat (RESET_CYCLES) @(posedge mclk);
		@(negedge mclk);
		rst = 1'b0;
		check_idle();
		run_vectors();
		@(posedge mclk);
		wait_drain();
		$display("Summary: %0d passed, %0d failed", pass_count + own_pass,
			fail_count + own_fail);
		if (fail_count + own_fail == 0 && pass_count > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== test/ym_op_vectors.txt ====
# behavior phase modulation eg_att expected_out
# phase, modulation and eg_att in hex, expected output in signed decimal
2 000 000 000 25
2 0ff 000 000 8168
2 080 000 000 5792
2 1ff 000 000 25
2 100 000 000 8168
2 17f 000 000 5792
2 0ff 000 040 4084
2 0ff 000 080 2042
2 0ff 000 0c0 1021
2 0ff 000 100 510
2 0ff 000 200 31
2 0ff 000 280 7
2 0ff 000 2c0 3
2 0ff 000 300 0
2 000 000 040 12
2 000 000 080 6
2 000 000 0c0 3
2 000 000 100 0
2 080 000 040 2896
2 080 000 080 1448
2 080 000 140 181
2 080 000 200 22
2 200 000 000 -25
2 2ff 000 000 -8168
3 0ff 000 000 8168
3 2ff 000 000 -8168
3 080 000 040 2896
3 280 000 040 -2896
3 1ff 000 080 6
3 3ff 000 080 -6
3 17f 000 000 5792
3 37f 000 000 -5792
3 100 000 0c0 1021
3 300 000 0c0 -1021
4 000 000 000 25
4 1ff 000 000 25
4 080 000 080 1448
4 17f 000 080 1448
4 0ff 000 100 510
4 100 000 100 510
4 000 000 0c0 3
4 1ff 000 0c0 3
5 0c0 03f 000 8168
5 0ff 000 000 8168
5 3f0 010 040 12
5 000 000 040 12
5 155 32b 000 5792
5 080 000 000 5792
5 2a5 05a 080 -2042
5 2ff 000 080 -2042
5 3ff 301 100 -510
5 300 000 100 -510
6 000 000 3ff 0
6 0ff 000 3ff 0
6 080 000 3ff 0
6 2ff 000 3ff 0
6 1a7 2c4 3ff 0
6 35e 0b9 3ff 0
6 17f 000 3ff 0

// ==== vlog.f ====
hdl/ym_op_pkg.sv
hdl/ym_op_phase.sv
hdl/ym_op_logsin.sv
hdl/ym_op_exp.sv
hdl/ym_op_core.sv
test/ym_op_checker.sv
test/tb_ym_op.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ym_op
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Regression passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard hdl/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
